/* harness_top.f */
+incdir+hdl
hdl/harness_pkg.sv
hdl/acc_core.sv
hdl/wb_core_bridge.sv
hdl/host_loader.sv
hdl/wb_ram.sv
hdl/harness_top.sv
tb/harness_tb.sv

/* hdl/acc_core.sv */
`default_nettype none

module acc_core (
    input  wire                 sys_clk,
    input  wire                 rst_i,
    output logic                req_valid_o,
    input  wire                 req_ready_i,
    output logic                req_we_o,
    output harness_pkg::addr_t  req_addr_o,
    output harness_pkg::word_t  req_wdata_o,
    input  wire harness_pkg::word_t rsp_rdata_i,
    output logic                halted_o
);
    import harness_pkg::*;

    typedef enum logic [2:0] {
        S_BOOT,
        S_FETCH,
        S_DECODE,
        S_DATA,
        S_HALT
    } state_t;

    state_t  state;
    addr_t   pc;
    word_t   acc;
    word_t   ir;       // Current instruction
    opcode_t op;
    addr_t   op_addr;

    assign op      = opcode_t'(ir[31:28]);
    assign op_addr = addr_t'(ir);             // Operand address in low bits

    // Request fields come straight from registers, so they hold while waiting
    assign req_valid_o = (state == S_FETCH) || (state == S_DATA);
    assign req_we_o    = (state == S_DATA) && (op == OP_STORE);
    assign req_addr_o  = (state == S_DATA) ? op_addr : pc;
    assign req_wdata_o = acc;
    assign halted_o    = (state == S_HALT);

    always_ff @(posedge sys_clk) begin
        if (rst_i) begin
            state <= S_BOOT;
            pc    <= '0;
            acc   <= '0;
        end else begin
            case (state)
                S_BOOT: state <= S_FETCH;  // One idle cycle out of reset
                S_FETCH: begin
                    if (req_ready_i) begin
                        pc    <= pc + 1'b1;
                        state <= S_DECODE;
                    end
                end
                S_DECODE: begin
                    case (op)
                        OP_LOAD, OP_ADD, OP_STORE: state <= S_DATA;
                        OP_DEC: begin
                            acc   <= acc - 1'b1;  // Wraps below zero
                            state <= S_FETCH;
                        end
                        OP_JNZ: begin
                            if (acc != '0) begin
                                pc <= op_addr;
                            end
                            state <= S_FETCH;
                        end
                        OP_HALT: state <= S_HALT;
                        default: state <= S_HALT;  // Unknown code stops the core
                    endcase
                end
                S_DATA: begin
                    if (req_ready_i) begin
                        if (op == OP_LOAD) begin
                            acc <= rsp_rdata_i;
                        end else if (op == OP_ADD) begin
                            acc <= acc + rsp_rdata_i;
                        end
                        state <= S_FETCH;
                    end
                end
                default: state <= S_HALT;  // Parked until reset
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (state == S_FETCH && req_ready_i) begin
            ir <= rsp_rdata_i;
        end
    end

    // Bus master must not change a pending request
    a_req_stable: assert property (
        @(posedge sys_clk) disable iff (rst_i)
        (req_valid_o && !req_ready_i) |=>
            (req_valid_o && $stable(req_addr_o) && $stable(req_we_o)
             && $stable(req_wdata_o))
    );

endmodule

`default_nettype wire

/* hdl/harness_params.svh */
`ifndef HARNESS_PARAMS_SVH
`define HARNESS_PARAMS_SVH

// Data word width in bits
`define HARNESS_DATA_W 32

// Word address width, one RAM word per address
`define HARNESS_ADDR_W 8

// RAM depth covers the full address space
`define HARNESS_MEM_WORDS 256

`endif

/* hdl/harness_pkg.sv */
`include "harness_params.svh"

`default_nettype none

package harness_pkg;

    typedef logic [`HARNESS_DATA_W-1:0]   word_t;
    typedef logic [`HARNESS_ADDR_W-1:0]   addr_t;
    typedef logic [`HARNESS_DATA_W/8-1:0] wstrb_t;  // One bit per byte lane

    // Opcode lives in instruction bits 31:28
    typedef enum logic [3:0] {
        OP_LOAD  = 4'h1,
        OP_ADD   = 4'h2,
        OP_STORE = 4'h3,
        OP_DEC   = 4'h4,
        OP_JNZ   = 4'h5,
        OP_HALT  = 4'hF
    } opcode_t;

    // Host command codes
    typedef enum logic [1:0] {
        CMD_WRITE = 2'd0,
        CMD_READ  = 2'd1,
        CMD_START = 2'd2
    } cmd_op_t;

endpackage

`default_nettype wire

/* hdl/harness_top.sv */
`default_nettype none

module harness_top (
    input  wire                       sys_clk,
    input  wire                       rst_i,
    input  wire                       cmd_valid_i,
    output logic                      cmd_ready_o,
    input  wire harness_pkg::cmd_op_t cmd_op_i,
    input  wire harness_pkg::addr_t   cmd_addr_i,
    input  wire harness_pkg::word_t   cmd_data_i,
    output logic                      rsp_valid_o,
    input  wire                       rsp_ready_i,
    output harness_pkg::word_t        rsp_data_o,
    output logic                      halted_o
);
    import harness_pkg::*;

    logic   core_rst;
    logic   core_halted;

    // Core request
    logic   req_valid;
    logic   req_ready;
    logic   req_we;
    addr_t  req_addr;
    word_t  req_wdata;
    word_t  rsp_rdata;

    // Bridge to loader
    logic   core_cyc;
    logic   core_stb;
    logic   core_we;
    wstrb_t core_sel;
    addr_t  core_adr;
    word_t  core_dat_w;
    word_t  core_dat_r;
    logic   core_ack;

    // Loader to RAM
    logic   ram_cyc;
    logic   ram_stb;
    logic   ram_we;
    wstrb_t ram_sel;
    addr_t  ram_adr;
    word_t  ram_dat_w;
    word_t  ram_dat_r;
    logic   ram_ack;

    acc_core core_i (
        .sys_clk     (sys_clk),
        .rst_i       (core_rst),
        .req_valid_o (req_valid),
        .req_ready_i (req_ready),
        .req_we_o    (req_we),
        .req_addr_o  (req_addr),
        .req_wdata_o (req_wdata),
        .rsp_rdata_i (rsp_rdata),
        .halted_o    (core_halted)
    );

    wb_core_bridge bridge_i (
        .sys_clk     (sys_clk),
        .rst_i       (core_rst),
        .req_valid_i (req_valid),
        .req_ready_o (req_ready),
        .req_we_i    (req_we),
        .req_addr_i  (req_addr),
        .req_wdata_i (req_wdata),
        .rsp_rdata_o (rsp_rdata),
        .wb_cyc_o    (core_cyc),
        .wb_stb_o    (core_stb),
        .wb_we_o     (core_we),
        .wb_sel_o    (core_sel),
        .wb_adr_o    (core_adr),
        .wb_dat_o    (core_dat_w),
        .wb_dat_i    (core_dat_r),
        .wb_ack_i    (core_ack)
    );

    host_loader loader_i (
        .sys_clk       (sys_clk),
        .rst_i         (rst_i),
        .cmd_valid_i   (cmd_valid_i),
        .cmd_ready_o   (cmd_ready_o),
        .cmd_op_i      (cmd_op_i),
        .cmd_addr_i    (cmd_addr_i),
        .cmd_data_i    (cmd_data_i),
        .rsp_valid_o   (rsp_valid_o),
        .rsp_ready_i   (rsp_ready_i),
        .rsp_data_o    (rsp_data_o),
        .core_rst_o    (core_rst),
        .core_halted_i (core_halted),
        .halted_o      (halted_o),
        .core_cyc_i    (core_cyc),
        .core_stb_i    (core_stb),
        .core_we_i     (core_we),
        .core_sel_i    (core_sel),
        .core_adr_i    (core_adr),
        .core_dat_i    (core_dat_w),
        .core_dat_o    (core_dat_r),
        .core_ack_o    (core_ack),
        .ram_cyc_o     (ram_cyc),
        .ram_stb_o     (ram_stb),
        .ram_we_o      (ram_we),
        .ram_sel_o     (ram_sel),
        .ram_adr_o     (ram_adr),
        .ram_dat_o     (ram_dat_w),
        .ram_dat_i     (ram_dat_r),
        .ram_ack_i     (ram_ack)
    );

    wb_ram ram_i (
        .sys_clk  (sys_clk),
        .rst_i    (rst_i),
        .wb_cyc_i (ram_cyc),
        .wb_stb_i (ram_stb),
        .wb_we_i  (ram_we),
        .wb_sel_i (ram_sel),
        .wb_adr_i (ram_adr),
        .wb_dat_i (ram_dat_w),
        .wb_dat_o (ram_dat_r),
        .wb_ack_o (ram_ack)
    );

endmodule

`default_nettype wire

/* hdl/host_loader.sv */
`default_nettype none

module host_loader (
    input  wire                         sys_clk,
    input  wire                         rst_i,
    input  wire                         cmd_valid_i,
    output logic                        cmd_ready_o,
    input  wire harness_pkg::cmd_op_t   cmd_op_i,
    input  wire harness_pkg::addr_t     cmd_addr_i,
    input  wire harness_pkg::word_t     cmd_data_i,
    output logic                        rsp_valid_o,
    input  wire                         rsp_ready_i,
    output harness_pkg::word_t          rsp_data_o,
    output logic                        core_rst_o,
    input  wire                         core_halted_i,
    output logic                        halted_o,
    input  wire                         core_cyc_i,
    input  wire                         core_stb_i,
    input  wire                         core_we_i,
    input  wire harness_pkg::wstrb_t    core_sel_i,
    input  wire harness_pkg::addr_t     core_adr_i,
    input  wire harness_pkg::word_t     core_dat_i,
    output harness_pkg::word_t          core_dat_o,
    output logic                        core_ack_o,
    output logic                        ram_cyc_o,
    output logic                        ram_stb_o,
    output logic                        ram_we_o,
    output harness_pkg::wstrb_t         ram_sel_o,
    output harness_pkg::addr_t          ram_adr_o,
    output harness_pkg::word_t          ram_dat_o,
    input  wire harness_pkg::word_t     ram_dat_i,
    input  wire                         ram_ack_i
);
    import harness_pkg::*;

    typedef enum logic [2:0] {
        L_RESET,
        L_IDLE,
        L_WRITE,
        L_READ,
        L_RSP,
        L_RUN
    } lstate_t;

    lstate_t state;
    addr_t   addr_q;
    word_t   data_q;
    logic    core_owns;
    logic    host_cyc;

    assign core_owns = (state == L_RUN);
    assign host_cyc  = (state == L_WRITE) || (state == L_READ);

    assign cmd_ready_o = (state == L_IDLE);
    assign core_rst_o  = !core_owns;  // Core only runs between START and HALT

    // Response shows in the ack cycle, then holds in L_RSP
    assign rsp_valid_o = (state == L_RSP) || (state == L_READ && ram_ack_i);
    assign rsp_data_o  = ram_dat_i;   // RAM keeps read data until its next access

    always_ff @(posedge sys_clk) begin
        if (rst_i) begin
            state    <= L_RESET;
            halted_o <= 1'b0;
        end else begin
            case (state)
                L_RESET: state <= L_IDLE;
                L_IDLE: begin
                    if (cmd_valid_i) begin
                        case (cmd_op_i)
                            CMD_WRITE: state <= L_WRITE;
                            CMD_READ:  state <= L_READ;
                            CMD_START: begin
                                state    <= L_RUN;
                                halted_o <= 1'b0;
                            end
                            default:   state <= L_IDLE;  // Dropped
                        endcase
                    end
                end
                L_WRITE: if (ram_ack_i) state <= L_IDLE;
                L_READ: begin
                    if (ram_ack_i) begin
                        state <= rsp_ready_i ? L_IDLE : L_RSP;
                    end
                end
                L_RSP: if (rsp_ready_i) state <= L_IDLE;
                L_RUN: begin
                    if (core_halted_i) begin
                        state    <= L_IDLE;  // Take the bus back
                        halted_o <= 1'b1;
                    end
                end
                default: state <= L_IDLE;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (cmd_valid_i && cmd_ready_o) begin
            addr_q <= cmd_addr_i;
            data_q <= cmd_data_i;
        end
    end

    // RAM port ownership
    assign ram_cyc_o = core_owns ? core_cyc_i : host_cyc;
    assign ram_stb_o = core_owns ? core_stb_i : host_cyc;
    assign ram_we_o  = core_owns ? core_we_i  : (state == L_WRITE);
    assign ram_sel_o = core_owns ? core_sel_i : '1;
    assign ram_adr_o = core_owns ? core_adr_i : addr_q;
    assign ram_dat_o = core_owns ? core_dat_i : data_q;

    assign core_dat_o = ram_dat_i;
    assign core_ack_o = core_owns && ram_ack_i;  // Host acks never reach the core

    // Core side stays quiet for the whole reset hold
    a_no_stb_in_reset: assert property (
        @(posedge sys_clk) disable iff (rst_i)
        core_rst_o |-> !core_stb_i
    );

endmodule

`default_nettype wire

/* hdl/wb_core_bridge.sv */
`default_nettype none

module wb_core_bridge (
    input  wire                     sys_clk,
    input  wire                     rst_i,
    input  wire                     req_valid_i,
    output logic                    req_ready_o,
    input  wire                     req_we_i,
    input  wire harness_pkg::addr_t req_addr_i,
    input  wire harness_pkg::word_t req_wdata_i,
    output harness_pkg::word_t      rsp_rdata_o,
    output logic                    wb_cyc_o,
    output logic                    wb_stb_o,
    output logic                    wb_we_o,
    output harness_pkg::wstrb_t     wb_sel_o,
    output harness_pkg::addr_t      wb_adr_o,
    output harness_pkg::word_t      wb_dat_o,
    input  wire harness_pkg::word_t wb_dat_i,
    input  wire                     wb_ack_i
);
    import harness_pkg::*;

    logic  ack_q;    // Slave ack delayed by one cycle
    word_t rdata_q;

    always_ff @(posedge sys_clk) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= wb_ack_i;
        end
    end

    always_ff @(posedge sys_clk) begin
        rdata_q <= wb_dat_i;
    end

    assign req_ready_o = ack_q;
    assign rsp_rdata_o = rdata_q;  // Lines up with the delayed ack

    // Strobe drops in the ready cycle so the slave does not see the request twice
    assign wb_cyc_o = req_valid_i;
    assign wb_stb_o = req_valid_i && !ack_q;
    assign wb_we_o  = req_we_i;
    assign wb_sel_o = '1;          // Word accesses only
    assign wb_adr_o = req_addr_i;
    assign wb_dat_o = req_wdata_i;

    // Loader gating and RAM handshake must keep acks inside a strobe
    a_ack_in_stb: assert property (
        @(posedge sys_clk) disable iff (rst_i)
        wb_ack_i |-> wb_stb_o
    );

endmodule

`default_nettype wire

/* hdl/wb_ram.sv */
`include "harness_params.svh"

`default_nettype none

module wb_ram (
    input  wire                      sys_clk,
    input  wire                      rst_i,
    input  wire                      wb_cyc_i,
    input  wire                      wb_stb_i,
    input  wire                      wb_we_i,
    input  wire harness_pkg::wstrb_t wb_sel_i,
    input  wire harness_pkg::addr_t  wb_adr_i,
    input  wire harness_pkg::word_t  wb_dat_i,
    output harness_pkg::word_t       wb_dat_o,
    output logic                     wb_ack_o
);
    import harness_pkg::*;

    word_t mem [`HARNESS_MEM_WORDS];
    logic  access;

    // New access only on the first strobe cycle with ack low
    assign access = wb_cyc_i && wb_stb_i && !wb_ack_o;

    always_ff @(posedge sys_clk) begin
        if (rst_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= access;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (access) begin
            if (wb_we_i) begin
                for (int b = 0; b < $bits(wstrb_t); b++) begin
                    if (wb_sel_i[b]) begin
                        mem[wb_adr_i][b*8 +: 8] <= wb_dat_i[b*8 +: 8];
                    end
                end
            end
            wb_dat_o <= mem[wb_adr_i];  // Old contents on a write
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f harness_top.f --top-module harness_tb -o harness_sim

./obj_dir/harness_sim > sim.log 2>&1
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

/* tb/harness_stimulus.txt */
# name  command  address(hex)  data(hex)  expected(hex)
# WRITE uses data, READ checks expected, START and WAITHALT ignore the value columns
wr_a00       WRITE    00 11111111 00000000
wr_a05       WRITE    05 a5a5a5a5 00000000
wr_aff       WRITE    ff deadbeef 00000000
rd_a00       READ     00 00000000 11111111
rd_a05       READ     05 00000000 a5a5a5a5
rd_aff       READ     ff 00000000 deadbeef
rd_a05_again READ     05 00000000 a5a5a5a5
p1_load      WRITE    00 10000080 00000000
p1_add       WRITE    01 20000081 00000000
p1_store     WRITE    02 30000082 00000000
p1_halt_op   WRITE    03 f0000000 00000000
p1_opnd_a    WRITE    80 fffffff0 00000000
p1_opnd_b    WRITE    81 00000025 00000000
p1_run       START    00 00000000 00000000
p1_wait      WAITHALT 00 00000000 00000000
p1_sum       READ     82 00000000 00000015
p1_opnd_keep READ     80 00000000 fffffff0
p2_load_cnt  WRITE    00 10000090 00000000
p2_add_sum   WRITE    01 20000091 00000000
p2_st_sum    WRITE    02 30000091 00000000
p2_reload    WRITE    03 10000090 00000000
p2_dec       WRITE    04 40000000 00000000
p2_st_cnt    WRITE    05 30000090 00000000
p2_jnz       WRITE    06 50000000 00000000
p2_halt_op   WRITE    07 f0000000 00000000
p2_cnt_init  WRITE    90 00000005 00000000
p2_sum_init  WRITE    91 00000000 00000000
p2_run       START    00 00000000 00000000
p2_wait      WAITHALT 00 00000000 00000000
p2_total     READ     91 00000000 0000000f
p2_cnt_end   READ     90 00000000 00000000
rd_aff_end   READ     ff 00000000 deadbeef

/* tb/harness_tb.sv */
`default_nettype none

module harness_tb;
    import harness_pkg::*;

    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 8;
    localparam int TIME_PER_LINE = 2000;  // Watchdog budget per stimulus line
    localparam int CMD_WAIT_MAX  = 100;
    localparam int HALT_WAIT_MAX = 1000;

    logic    sys_clk;
    logic    rst_i;
    logic    cmd_valid_i;
    logic    cmd_ready_o;
    cmd_op_t cmd_op_i;
    addr_t   cmd_addr_i;
    word_t   cmd_data_i;
    logic    rsp_valid_o;
    logic    rsp_ready_i;
    word_t   rsp_data_o;
    logic    halted_o;

    // Stimulus table, one entry per test line
    string t_name[$];
    string t_cmd[$];
    addr_t t_addr[$];
    word_t t_data[$];
    word_t t_exp[$];

    word_t rsp_q[$];   // Host responses in arrival order
    int    rsp_count;
    int    read_count;
    int    fail_tests;
    int    err_count;
    logic  loaded;
    logic  test_ok;

    harness_top dut_i (
        .sys_clk     (sys_clk),
        .rst_i       (rst_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_ready_o (cmd_ready_o),
        .cmd_op_i    (cmd_op_i),
        .cmd_addr_i  (cmd_addr_i),
        .cmd_data_i  (cmd_data_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_data_o  (rsp_data_o),
        .halted_o    (halted_o)
    );

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    // Random back-pressure, ready on about three cycles in four
    initial begin
        void'($urandom(35255));
        rsp_ready_i <= 1'b0;
        forever begin
            @(posedge sys_clk);
            rsp_ready_i <= (($urandom % 4) != 0);
        end
    end

    // Every completed response handshake lands in the queue
    always @(negedge sys_clk) begin
        if (!rst_i && rsp_valid_o && rsp_ready_i) begin
            rsp_q.push_back(rsp_data_o);
            rsp_count++;
        end
    end

    initial begin
        wait (loaded === 1'b1);
        #((t_name.size() * TIME_PER_LINE) + (RESET_CYCLES * CLK_PERIOD));
        $display("ERROR: watchdog expired before the tests finished");
        $display("Finished with errors");
        $finish;
    end

    task automatic send_cmd(input cmd_op_t op, input addr_t addr, input word_t data);
        int waited;
        waited = 0;
        @(posedge sys_clk);
        cmd_valid_i <= 1'b1;
        cmd_op_i    <= op;
        cmd_addr_i  <= addr;
        cmd_data_i  <= data;
        @(negedge sys_clk);
        while (!cmd_ready_o && waited < CMD_WAIT_MAX) begin
            @(negedge sys_clk);
            waited++;
        end
        assert (cmd_ready_o) else begin
            $display("ERROR: loader never accepted the command");
            test_ok = 1'b0;
        end
        @(posedge sys_clk);  // Taken on this edge
        cmd_valid_i <= 1'b0;
    endtask

    task automatic do_read(input string name, input addr_t addr, input word_t exp);
        int    waited;
        word_t got;
        waited = 0;
        got    = '0;
        send_cmd(CMD_READ, addr, '0);
        read_count++;
        while (rsp_q.size() == 0 && waited < CMD_WAIT_MAX) begin
            @(posedge sys_clk);
            waited++;
        end
        assert (rsp_q.size() != 0) else begin
            $display("ERROR: %s received no read response", name);
            test_ok = 1'b0;
        end
        if (rsp_q.size() != 0) begin
            got = rsp_q.pop_front();
            assert (got == exp) else begin
                $display("FAIL %s expected %h actual %h", name, exp, got);
                test_ok = 1'b0;
            end
        end
    endtask

    task automatic wait_halt(input string name);
        int waited;
        waited = 0;
        @(negedge sys_clk);
        while (!halted_o && waited < HALT_WAIT_MAX) begin
            @(negedge sys_clk);
            waited++;
        end
        assert (halted_o) else begin
            $display("ERROR: %s core did not halt within %0d cycles", name, HALT_WAIT_MAX);
            test_ok = 1'b0;
        end
    endtask

    initial begin
        int    fd;
        int    n;
        string line;
        string name;
        string cmd;
        addr_t addr;
        word_t data;
        word_t exp;

        rst_i       <= 1'b1;
        cmd_valid_i <= 1'b0;
        cmd_op_i    <= CMD_WRITE;
        cmd_addr_i  <= '0;
        cmd_data_i  <= '0;
        rsp_count  = 0;
        read_count = 0;
        fail_tests = 0;
        err_count  = 0;
        loaded     = 1'b0;

        fd = $fopen("tb/harness_stimulus.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open the stimulus file");
            err_count++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    if ($sscanf(line, "%s %s %h %h %h", name, cmd, addr, data, exp) == 5) begin
                        t_name.push_back(name);
                        t_cmd.push_back(cmd);
                        t_addr.push_back(addr);
                        t_data.push_back(data);
                        t_exp.push_back(exp);
                    end
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge sys_clk);
        rst_i <= 1'b0;
        @(negedge sys_clk);
        assert (!cmd_ready_o && !rsp_valid_o && !halted_o) else begin
            $display("ERROR: host port outputs not idle right after reset");
            err_count++;
        end

        for (int i = 0; i < t_name.size(); i++) begin
            test_ok = 1'b1;
            if (t_cmd[i] == "WRITE") begin
                send_cmd(CMD_WRITE, t_addr[i], t_data[i]);
            end else if (t_cmd[i] == "READ") begin
                do_read(t_name[i], t_addr[i], t_exp[i]);
            end else if (t_cmd[i] == "START") begin
                send_cmd(CMD_START, '0, '0);
            end else if (t_cmd[i] == "WAITHALT") begin
                wait_halt(t_name[i]);
            end else begin
                $display("ERROR: %s has an unknown command %s", t_name[i], t_cmd[i]);
                test_ok = 1'b0;
            end
            if (test_ok) begin
                $display("PASS %s %s", t_name[i], t_cmd[i]);
            end else begin
                fail_tests++;
            end
        end

        // Room for a late duplicate response to show up
        repeat (4) @(posedge sys_clk);
        assert (rsp_q.size() == 0 && rsp_count == read_count) else begin
            $display("ERROR: %0d responses seen for %0d reads", rsp_count, read_count);
            err_count++;
        end

        $display("Tests run: %0d, failed: %0d, other errors: %0d",
                 t_name.size(), fail_tests, err_count);
        if (fail_tests == 0 && err_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
